/* project.f */
+incdir+hdl
+incdir+bench
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/core_top.sv
bench/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds core_tb with Verilator and runs it, exit status is the test result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f project.f --top-module core_tb -Mdir obj_dir &&
  ./obj_dir/Vcore_tb ||
  { echo "core_tb build or simulation failed"; exit 1; }

/* bench/ref_model.svh */
/*
 * instruction-set model for the core testbench
 * runs a generated program from its fields and queues the expected retires
 */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// instruction kinds the program generator can emit
typedef enum int {
  k_add, k_sub, k_and, k_or, k_xor, k_slt,
  k_addi, k_andi, k_ori, k_xori, k_slti,
  k_lui, k_auipc, k_lw, k_sw,
  k_beq, k_bne, k_blt, k_bge, k_jal, k_jalr,
  k_ebreak, k_bad
} kind_t;

// program under test, one entry per instruction word
kind_t    prog_kind [`IMEM_WORDS];
reg_idx_t prog_rd   [`IMEM_WORDS];
reg_idx_t prog_rs1  [`IMEM_WORDS];
reg_idx_t prog_rs2  [`IMEM_WORDS];
word_t    prog_imm  [`IMEM_WORDS];

// architectural state
word_t m_regs [`NUM_REGS];
// data RAM has no reset, so this one carries over between programs
word_t m_dmem [`DMEM_WORDS];

// expected retire records, oldest first
word_t exp_pc    [$];
word_t exp_rd    [$];
word_t exp_wdata [$];

task automatic run_model();
  word_t      pc;
  word_t      next_pc;
  word_t      a;
  word_t      b;
  word_t      addr;
  word_t      wd;
  logic [5:0] idx;
  reg_idx_t   rd_eff;
  bit         writes;
  bit         done;
  int         steps;
  pc    = `PC_RESET;
  done  = 1'b0;
  steps = 0;
  // reset clears the register file
  for (int r = 0; r < `NUM_REGS; r++) begin
    m_regs[r] = '0;
  end
  while (!done) begin
    if (steps >= `IMEM_WORDS) begin
      $display("reference model ran past the end of instruction memory");
      stop_with_failure();
    end
    idx     = pc[7:2];
    a       = m_regs[prog_rs1[idx]];
    b       = m_regs[prog_rs2[idx]];
    addr    = a + prog_imm[idx];
    wd      = '0;
    next_pc = pc + 32'd4;
    case (prog_kind[idx])
      k_add:   wd = a + b;
      k_sub:   wd = a - b;
      k_and:   wd = a & b;
      k_or:    wd = a | b;
      k_xor:   wd = a ^ b;
      k_slt:   wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      k_addi:  wd = a + prog_imm[idx];
      k_andi:  wd = a & prog_imm[idx];
      k_ori:   wd = a | prog_imm[idx];
      k_xori:  wd = a ^ prog_imm[idx];
      k_slti:  wd = ($signed(a) < $signed(prog_imm[idx])) ? 32'd1 : 32'd0;
      k_lui:   wd = prog_imm[idx];
      k_auipc: wd = pc + prog_imm[idx];
      // word index from address bits 7:2
      k_lw:    wd = m_dmem[addr[7:2]];
      k_sw:    m_dmem[addr[7:2]] = b;
      k_beq:   if (a == b) next_pc = pc + prog_imm[idx];
      k_bne:   if (a != b) next_pc = pc + prog_imm[idx];
      k_blt:   if ($signed(a) < $signed(b)) next_pc = pc + prog_imm[idx];
      k_bge:   if ($signed(a) >= $signed(b)) next_pc = pc + prog_imm[idx];
      k_jal: begin
        wd      = pc + 32'd4;
        next_pc = pc + prog_imm[idx];
      end
      k_jalr: begin
        wd      = pc + 32'd4;
        next_pc = addr & ~32'd1;
      end
      // ebreak or illegal word, retires with no write and halts
      default: done = 1'b1;
    endcase
    writes = !(prog_kind[idx] inside {k_sw, k_beq, k_bne, k_blt, k_bge, k_ebreak, k_bad});
    rd_eff = writes ? prog_rd[idx] : '0;
    if (rd_eff != '0) begin
      m_regs[rd_eff] = wd;
    end else begin
      wd = '0;
    end
    exp_pc.push_back(pc);
    exp_rd.push_back(word_t'(rd_eff));
    exp_wdata.push_back(wd);
    pc    = next_pc;
    steps = steps + 1;
  end
endtask

`endif

/* bench/core_tb.sv */
/*
 * testbench for the two-stage rv32i subset core
 * random forward-only programs from a fixed seed, each retire checked
 * against the instruction-set model
 */
`timescale 1ns/1ns
`include "rv_consts.svh"

module core_tb
  import rv_pkg::*;
();

  localparam int num_progs   = 8;
  // words before the closing ebreak
  localparam int prog_len    = 40;
  // this program gets an undefined opcode as its fifth word
  localparam int bad_prog    = 5;
  localparam int cycle_limit = num_progs * (`IMEM_WORDS + 2 * (prog_len + 1) + 20);

  logic     clk;
  logic     rst_n;
  logic     load_en;
  logic     start;
  word_t    load_addr;
  word_t    load_data;
  logic     retire_valid;
  word_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_wdata;
  logic     halted;
  logic     illegal;

  int          seed;
  int          cycle_count = 0;
  // data words that a store is certain to have written
  logic [15:0] dm_defined;

  `include "ref_model.svh"

  core_top core_top_i (
    .clk, .rst_n, .load_en, .load_addr, .load_data, .start,
    .retire_valid, .retire_pc, .retire_rd, .retire_wdata, .halted, .illegal
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout, no halt after %0d cycles", cycle_count);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("Something failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s expected %08h got %08h", name, exp, got);
      stop_with_failure();
    end
  endtask

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic word_t encode(input kind_t k, input reg_idx_t rd, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input word_t imm);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (k == k_sub) ? `F7_SUB : `F7_BASE;
    case (k)
      k_slt, k_slti: f3 = `F3_SLT;
      k_xor, k_xori: f3 = `F3_XOR;
      k_or, k_ori:   f3 = `F3_OR;
      k_and, k_andi: f3 = `F3_AND;
      k_lw:          f3 = `F3_LW;
      k_sw:          f3 = `F3_SW;
      k_beq:         f3 = `F3_BEQ;
      k_bne:         f3 = `F3_BNE;
      k_blt:         f3 = `F3_BLT;
      k_bge:         f3 = `F3_BGE;
      k_jalr:        f3 = `F3_JALR;
      default:       f3 = `F3_ADD;
    endcase
    case (k)
      k_add, k_sub, k_and, k_or, k_xor, k_slt:
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
      k_addi, k_andi, k_ori, k_xori, k_slti:
        return {imm[11:0], rs1, f3, rd, `OPC_OP_IMM};
      k_lui:   return {imm[31:12], rd, `OPC_LUI};
      k_auipc: return {imm[31:12], rd, `OPC_AUIPC};
      k_lw:    return {imm[11:0], rs1, f3, rd, `OPC_LOAD};
      k_sw:    return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
      k_beq, k_bne, k_blt, k_bge:
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
      k_jal:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
      k_jalr:  return {imm[11:0], rs1, f3, rd, `OPC_JALR};
      k_ebreak: return `EBREAK_INST;
      // opcode 7'h7f lies outside the subset
      // rd and rs1 stay filled in like an i-type word
      default: return {12'h000, rs1, 3'b000, rd, 7'h7f};
    endcase
  endfunction

  task automatic set_inst(input int i, input kind_t k, input int rd, input int rs1,
                          input word_t imm);
    prog_kind[i] = k;
    prog_rd[i]   = reg_idx_t'(rd);
    prog_rs1[i]  = reg_idx_t'(rs1);
    prog_rs2[i]  = '0;
    prog_imm[i]  = imm;
  endtask

  task automatic build_program(input int p);
    int reach;
    int tgt;
    int off;
    int sel;
    bit bad;
    bit dead;
    bad  = (p == bad_prog);
    dead = 1'b0;
    // fixed prologue sets x5 to 0 with auipc
    // jalr clears bit 0 of its target 13 and lands on word 3
    set_inst(0, k_auipc, 5, 0, 32'd0);
    set_inst(1, k_jalr, 6, 5, 32'd13);
    set_inst(2, k_addi, 7, 0, 32'h7ff);
    // every word at or past reach is sure to execute
    reach = 3;
    for (int i = 3; i < prog_len; i++) begin
      sel          = rand_below(20);
      prog_rd[i]   = reg_idx_t'(rand_below(8));
      prog_rs1[i]  = reg_idx_t'(rand_below(8));
      prog_rs2[i]  = reg_idx_t'(rand_below(8));
      prog_imm[i]  = word_t'(rand_below(4096) - 2048);
      // the word ahead of the illegal one must not jump over it
      if (bad && i == 3) sel = 0;
      if (bad && i == 4) begin
        prog_kind[i] = k_bad;
        // nonzero rd so that a write by the illegal word shows in retire_rd
        prog_rd[i]   = reg_idx_t'(1 + rand_below(7));
        dead         = 1'b1;
      end else if (sel < 5) begin
        prog_kind[i] = kind_t'(int'(k_add) + rand_below(6));
      end else if (sel < 10) begin
        prog_kind[i] = kind_t'(int'(k_addi) + rand_below(5));
      end else if (sel < 12) begin
        prog_kind[i] = (sel == 10) ? k_lui : k_auipc;
        prog_imm[i]  = word_t'(rand_below(1 << 20)) << 12;
      end else if (sel < 14) begin
        // base x0 with word offsets 0..60
        off          = rand_below(16);
        prog_rs1[i]  = '0;
        prog_imm[i]  = word_t'(off * 4);
        if (sel == 12 && dm_defined[off]) begin
          prog_kind[i] = k_lw;
        end else begin
          prog_kind[i] = k_sw;
          if (!dead && i >= reach) dm_defined[off] = 1'b1;
        end
      end else begin
        prog_kind[i] = (sel < 18) ? kind_t'(int'(k_beq) + rand_below(4)) : k_jal;
        tgt          = i + 2 + rand_below(4);
        if (tgt > prog_len) tgt = prog_len;
        prog_imm[i]  = word_t'((tgt - i) * 4);
        if (tgt > reach) reach = tgt;
      end
    end
    set_inst(prog_len, k_ebreak, 0, 0, 32'd0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic load_program();
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      @(posedge clk);
      #1;
      load_en   = 1'b1;
      load_addr = word_t'(i * 4);
      if (i <= prog_len) begin
        load_data = encode(prog_kind[i], prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
      end else begin
        // unused words hold addi x0,x0,<index>
        load_data = `NOP_INST | (word_t'(i) << 20);
      end
      // core must stay quiet until start
      check_value("retire_valid", word_t'(retire_valid), 32'd0);
      check_value("halted", word_t'(halted), 32'd0);
      check_value("illegal", word_t'(illegal), 32'd0);
    end
    @(posedge clk);
    #1;
    load_en = 1'b0;
    start   = 1'b1;
    @(posedge clk);
    #1;
    start   = 1'b0;
  endtask

  task automatic watch_retires(input bit expect_bad);
    bit seen_halt;
    seen_halt = 1'b0;
    while (!seen_halt) begin
      @(negedge clk);
      if (retire_valid) begin
        if (exp_pc.size() == 0) begin
          $display("retire seen after the model had halted, pc %08h", retire_pc);
          stop_with_failure();
        end
        check_value("retire_pc", retire_pc, exp_pc.pop_front());
        check_value("retire_rd", word_t'(retire_rd), exp_rd.pop_front());
        check_value("retire_wdata", retire_wdata, exp_wdata.pop_front());
      end
      seen_halt = halted;
    end
    if (exp_pc.size() != 0) begin
      $display("retire queue not empty at halt");
      stop_with_failure();
    end
    check_value("illegal", word_t'(illegal), word_t'(expect_bad));
    // halt holds until reset and nothing more retires
    repeat (4) begin
      @(negedge clk);
      check_value("retire_valid", word_t'(retire_valid), 32'd0);
      check_value("halted", word_t'(halted), 32'd1);
    end
  endtask

  initial begin
    seed       = 72897;
    rst_n      = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    start      = 1'b0;
    dm_defined = '0;
    for (int p = 0; p < num_progs; p++) begin
      build_program(p);
      apply_reset();
      run_model();
      load_program();
      watch_retires(p == bad_prog);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

/* hdl/core_top.sv */
/*
 * two-stage rv32i subset core
 * fetch, then decode/execute/memory/writeback in one cycle, with retire
 * reporting and halt on ebreak or an illegal instruction
 */
`timescale 1ns/1ns

module core_top
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load_en,
  input  word_t    load_addr,
  input  word_t    load_data,
  input  logic     start,
  output logic     retire_valid,
  output word_t    retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_wdata,
  output logic     halted,
  output logic     illegal
);

  word_t       ifid_pc, ifid_inst, pc, redirect_pc;
  logic        ifid_valid, redirect, stop;
  core_state_t state;
  reg_idx_t    rs1, rs2, rd;
  word_t       imm;
  alu_op_t     alu_op;
  logic        reg_wen, mem_wen, is_load, is_branch, is_jal, is_jalr;
  logic        is_auipc, need_imm, is_ebreak, is_illegal;
  word_t       rdata1, rdata2, alu_a, alu_b, alu_result, mem_rdata;
  word_t       pc_plus4, rf_wdata;
  logic        rf_wen, dm_wen, taken;

  fetch_unit fetch_unit_i (
    .clk, .rst_n, .load_en, .load_addr, .load_data, .start,
    .redirect, .redirect_pc, .stop,
    .ifid_pc, .ifid_inst, .ifid_valid, .pc, .state
  );

  decoder decoder_i (
    .inst (ifid_inst),
    .rs1, .rs2, .rd, .imm, .alu_op,
    .reg_wen, .mem_wen, .is_load, .is_branch, .is_jal, .is_jalr,
    .is_auipc, .need_imm, .is_ebreak, .is_illegal
  );

  reg_file reg_file_i (
    .clk, .rst_n,
    .wen (rf_wen), .waddr (rd), .wdata (rf_wdata),
    .raddr1 (rs1), .raddr2 (rs2), .rdata1, .rdata2
  );

  // operand a: pc for auipc/jal, operand b: imm or rs2
  assign alu_a = (is_auipc || is_jal) ? ifid_pc : rdata1;
  assign alu_b = need_imm ? imm : rdata2;

  alu alu_i (.a (alu_a), .b (alu_b), .op (alu_op), .result (alu_result));

  data_mem data_mem_i (
    .clk, .wen (dm_wen), .addr (alu_result), .wdata (rdata2), .rdata (mem_rdata)
  );

  // bubbles never write or redirect
  assign rf_wen = ifid_valid && reg_wen;
  assign dm_wen = ifid_valid && mem_wen;
  assign stop   = ifid_valid && (is_ebreak || is_illegal);

  // next pc, branch taken when the compare gives 1
  assign taken       = is_branch && (alu_result == 32'd1);
  assign redirect    = ifid_valid && (taken || is_jal || is_jalr);
  assign redirect_pc = is_jalr ? (alu_result & ~32'd1) : (ifid_pc + imm);

  // writeback select, link address for jumps
  assign pc_plus4 = ifid_pc + 32'd4;
  assign rf_wdata = (is_jal || is_jalr) ? pc_plus4 : (is_load ? mem_rdata : alu_result);

  // retire record, rd and wdata zero when no register is written
  assign retire_valid = ifid_valid;
  assign retire_pc    = ifid_pc;
  assign retire_rd    = rf_wen ? rd : '0;
  assign retire_wdata = (retire_rd != '0) ? rf_wdata : '0;

  assign halted = (state == st_halt);

  // sticky cause, rises on the same edge as halt
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      illegal <= 1'b0;
    end else if (ifid_valid && is_illegal) begin
      illegal <= 1'b1;
    end
  end

  // illegal word writes nothing, then the core halts flagging illegal
  a_illegal_halts: assert property (
    @(posedge clk) disable iff (!rst_n)
      (ifid_valid && is_illegal) |-> !(rf_wen || dm_wen) ##1 (halted && illegal)
  );

  // fetch follows the execute-stage redirect on the next edge
  a_redirect_pc: assert property (
    @(posedge clk) disable iff (!rst_n) redirect |=> (pc == $past(redirect_pc))
  );

endmodule

/* hdl/data_mem.sv */
/*
 * data memory
 * word RAM, combinational read, synchronous write, word index from addr[7:2]
 */
`timescale 1ns/1ns
`include "rv_consts.svh"

module data_mem
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  wen,
  input  word_t addr,
  input  word_t wdata,
  output word_t rdata
);

  localparam int DMEM_AW = $clog2(`DMEM_WORDS);

  word_t                mem [`DMEM_WORDS];
  logic [DMEM_AW-1:0]   widx;

  // byte address to word index, low two bits ignored
  assign widx = addr[DMEM_AW+1:2];

  // lw result available in the same cycle
  assign rdata = mem[widx];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[widx] <= wdata;
    end
  end

endmodule

/* hdl/alu.sv */
/*
 * alu
 * add, sub, logic, signed compare and the branch conditions
 */
`timescale 1ns/1ns

module alu
  import rv_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result
);

  logic lt_s;

  // signed compare shared by slt, blt and bge
  assign lt_s = ($signed(a) < $signed(b));

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_slt:    result = {31'b0, lt_s};
      // lui, immediate already shifted by the decoder
      alu_pass_b: result = b;
      // branch ops give 1 when taken
      alu_eq:     result = {31'b0, (a == b)};
      alu_ne:     result = {31'b0, (a != b)};
      alu_lt:     result = {31'b0, lt_s};
      alu_ge:     result = {31'b0, !lt_s};
      default:    result = '0;
    endcase
  end

endmodule

/* hdl/reg_file.sv */
/*
 * integer register file
 * 32 x 32 bits, x0 reads zero, two async reads, one sync write
 */
`timescale 1ns/1ns
`include "rv_consts.svh"

module reg_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  word_t    wdata,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  output word_t    rdata1,
  output word_t    rdata2
);

  word_t regs [`NUM_REGS];

  // writes to x0 dropped, so regs[0] stays at its reset zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // x0 reads zero on both ports, even after writes aimed at it
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
      ((raddr1 == '0) -> (rdata1 == '0)) && ((raddr2 == '0) -> (rdata2 == '0))
  );

endmodule

/* hdl/decoder.sv */
/*
 * instruction decoder
 * register fields, immediates, alu op and control flags for the rv32i subset
 */
`timescale 1ns/1ns
`include "rv_consts.svh"

module decoder
  import rv_pkg::*;
(
  input  word_t    inst,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output alu_op_t  alu_op,
  output logic     reg_wen,
  output logic     mem_wen,
  output logic     is_load,
  output logic     is_branch,
  output logic     is_jal,
  output logic     is_jalr,
  output logic     is_auipc,
  output logic     need_imm,
  output logic     is_ebreak,
  output logic     is_illegal
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = inst[6:0];
  assign f3     = inst[14:12];
  assign f7     = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  // immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm        = imm_i;
    alu_op     = alu_add;
    reg_wen    = 1'b0;
    mem_wen    = 1'b0;
    is_load    = 1'b0;
    is_branch  = 1'b0;
    is_jal     = 1'b0;
    is_jalr    = 1'b0;
    is_auipc   = 1'b0;
    need_imm   = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;
    case (opcode)
      `OPC_OP: begin
        reg_wen = 1'b1;
        case (f3)
          `F3_ADD: alu_op = (f7 == `F7_SUB) ? alu_sub : alu_add;
          `F3_SLT: alu_op = alu_slt;
          `F3_XOR: alu_op = alu_xor;
          `F3_OR:  alu_op = alu_or;
          `F3_AND: alu_op = alu_and;
          default: is_illegal = 1'b1;
        endcase
        // only add may carry the alternate funct7
        if (f7 != `F7_BASE && !(f7 == `F7_SUB && f3 == `F3_ADD)) is_illegal = 1'b1;
      end
      `OPC_OP_IMM: begin
        reg_wen  = 1'b1;
        need_imm = 1'b1;
        case (f3)
          `F3_ADD: alu_op = alu_add;
          `F3_SLT: alu_op = alu_slt;
          `F3_XOR: alu_op = alu_xor;
          `F3_OR:  alu_op = alu_or;
          `F3_AND: alu_op = alu_and;
          default: is_illegal = 1'b1;
        endcase
      end
      `OPC_LUI: begin
        reg_wen  = 1'b1;
        need_imm = 1'b1;
        imm      = imm_u;
        alu_op   = alu_pass_b;
      end
      `OPC_AUIPC: begin
        reg_wen  = 1'b1;
        need_imm = 1'b1;
        is_auipc = 1'b1;
        imm      = imm_u;
      end
      `OPC_LOAD: begin
        reg_wen    = 1'b1;
        need_imm   = 1'b1;
        is_load    = 1'b1;
        is_illegal = (f3 != `F3_LW);
      end
      `OPC_STORE: begin
        mem_wen    = 1'b1;
        need_imm   = 1'b1;
        imm        = imm_s;
        is_illegal = (f3 != `F3_SW);
      end
      `OPC_BRANCH: begin
        // alu compares rs1 with rs2, target adder uses imm
        is_branch = 1'b1;
        imm       = imm_b;
        case (f3)
          `F3_BEQ: alu_op = alu_eq;
          `F3_BNE: alu_op = alu_ne;
          `F3_BLT: alu_op = alu_lt;
          `F3_BGE: alu_op = alu_ge;
          default: is_illegal = 1'b1;
        endcase
      end
      `OPC_JAL: begin
        reg_wen  = 1'b1;
        need_imm = 1'b1;
        is_jal   = 1'b1;
        imm      = imm_j;
      end
      `OPC_JALR: begin
        reg_wen    = 1'b1;
        need_imm   = 1'b1;
        is_jalr    = 1'b1;
        is_illegal = (f3 != `F3_JALR);
      end
      `OPC_SYSTEM: begin
        // ebreak is the only system instruction kept
        is_ebreak  = (inst == `EBREAK_INST);
        is_illegal = (inst != `EBREAK_INST);
      end
      default: is_illegal = 1'b1;
    endcase
    // an illegal word must not touch state
    if (is_illegal) begin
      reg_wen = 1'b0;
      mem_wen = 1'b0;
    end
  end

endmodule

/* hdl/fetch_unit.sv */
/*
 * fetch stage
 * pc register, instruction memory with load port, if/id register with flush
 * and the idle/run/halt state machine
 */
`timescale 1ns/1ns
`include "rv_consts.svh"

module fetch_unit
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        load_en,
  input  word_t       load_addr,
  input  word_t       load_data,
  input  logic        start,
  input  logic        redirect,
  input  word_t       redirect_pc,
  input  logic        stop,
  output word_t       ifid_pc,
  output word_t       ifid_inst,
  output logic        ifid_valid,
  output word_t       pc,
  output core_state_t state
);

  localparam int IMEM_AW = $clog2(`IMEM_WORDS);

  word_t       imem [`IMEM_WORDS];
  core_state_t state_nxt;
  logic        fetch_en;

  // program load, byte address, idle only
  always_ff @(posedge clk) begin
    if (load_en && (state == st_idle)) begin
      imem[load_addr[IMEM_AW+1:2]] <= load_data;
    end
  end

  // idle -> run on start, run -> halt on stop
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: if (start) state_nxt = st_run;
      st_run:  if (stop) state_nxt = st_halt;
      default: state_nxt = state;
    endcase
  end

  // a word moves into if/id only in run, with no stop or redirect pending
  assign fetch_en = (state == st_run) && !stop && !redirect;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_idle;
      pc         <= `PC_RESET;
      ifid_valid <= 1'b0;
      ifid_inst  <= `NOP_INST;
    end else begin
      state <= state_nxt;
      if (fetch_en) begin
        pc         <= pc + 32'd4;
        ifid_inst  <= imem[pc[IMEM_AW+1:2]];
        ifid_valid <= 1'b1;
      end else begin
        // taken branch or jump, skip the word fetched behind it
        if ((state == st_run) && !stop && redirect) begin
          pc <= redirect_pc;
        end
        ifid_inst  <= `NOP_INST;
        ifid_valid <= 1'b0;
      end
    end
  end

  // pc of the instruction held in if/id
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      ifid_pc <= pc;
    end
  end

  // nothing may execute before start
  a_idle_no_valid: assert property (
    @(posedge clk) disable iff (!rst_n) (state == st_idle) |-> !ifid_valid
  );

endmodule

/* hdl/rv_pkg.sv */
/*
 * shared types of the two-stage rv32i subset core
 * data words, register indices, alu operations and core run state
 */
package rv_pkg;

  // data or byte address
  typedef logic [31:0] word_t;

  // architectural register number
  typedef logic [4:0] reg_idx_t;

  // alu operation select
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    // signed set-less-than
    alu_slt    = 4'd5,
    // lui passes the immediate through
    alu_pass_b = 4'd6,
    // branch compares, result is 1 when taken
    alu_eq     = 4'd7,
    alu_ne     = 4'd8,
    alu_lt     = 4'd9,
    alu_ge     = 4'd10
  } alu_op_t;

  // core run state
  typedef enum logic [1:0] {
    // waiting for program load and start
    st_idle = 2'd0,
    st_run  = 2'd1,
    // ebreak or illegal seen, only reset leaves this
    st_halt = 2'd2
  } core_state_t;

endpackage

/* hdl/rv_consts.svh */
/*
 * rv32i subset core constants
 * memory depths, reset pc, register count and instruction field encodings
 */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// memory depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 64
`define NUM_REGS   32
`define PC_RESET   32'h0000_0000

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_SYSTEM 7'b1110011

// funct3, alu group
`define F3_ADD  3'b000
`define F3_SLT  3'b010
`define F3_XOR  3'b100
`define F3_OR   3'b110
`define F3_AND  3'b111
// funct3, memory and jumps
`define F3_LW   3'b010
`define F3_SW   3'b010
`define F3_JALR 3'b000
// funct3, branches
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101

// funct7 for register-register ops
`define F7_BASE 7'b0000000
`define F7_SUB  7'b0100000

// addi x0,x0,0 and ebreak
`define NOP_INST    32'h0000_0013
`define EBREAK_INST 32'h0010_0073

`endif
